//--- logic/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

////////////////////////////////////////
// Segment geometry
////////////////////////////////////////

// Word index inside one segment
`define SEG_BITS 5
// Segment number
`define SEG_COUNT_BITS 5
`define ADDR_BITS (`SEG_COUNT_BITS + `SEG_BITS)
`define WORD_BITS 16

// Preloaded segment range
`define BOOT_FIRST 1
`define BOOT_LAST 30

// Low field of the boot words
`define TAG0 5'h0A
`define TAG1 5'h0E

////////////////////////////////////////
// Host bus
////////////////////////////////////////

`define AXI_ADDR_BITS 8
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS (`AXI_DATA_BITS / 8)

`endif

//--- logic/memTypesPkg.sv
`include "mem_consts.svh"

package memTypesPkg;

	// One word of either bank
	typedef logic [`WORD_BITS-1:0] bankWord;

	// Segment number in the upper bits, word index in the lower bits
	typedef logic [`ADDR_BITS-1:0] bankAddr;

	typedef logic [`SEG_COUNT_BITS-1:0] segNum;

	// Boot loader states
	typedef enum logic [1:0] {
		Idle,
		Load,
		Run
	} seqState;

	// One access to one bank
	typedef struct packed {
		logic en;
		logic we;
		bankAddr addr;
		bankWord data;
	} bankReq;

endpackage

//--- logic/axiLitePkg.sv
`include "mem_consts.svh"

package axiLitePkg;

	typedef logic [1:0] axiResp;

	// Only OKAY is ever returned
	localparam axiResp respOkay = 2'b00;

	////////////////////////////////////////
	// Address channels
	////////////////////////////////////////

	typedef struct packed {
		logic [`AXI_ADDR_BITS-1:0] addr;
		logic [2:0] prot;
	} axiAw;

	typedef struct packed {
		logic [`AXI_ADDR_BITS-1:0] addr;
		logic [2:0] prot;
	} axiAr;

	////////////////////////////////////////
	// Data and response channels
	////////////////////////////////////////

	typedef struct packed {
		logic [`AXI_DATA_BITS-1:0] data;
		logic [`AXI_STRB_BITS-1:0] strb;
	} axiW;

	typedef struct packed {
		axiResp resp;
	} axiB;

	typedef struct packed {
		logic [`AXI_DATA_BITS-1:0] data;
		axiResp resp;
	} axiR;

endpackage

//--- logic/initSequencer.sv
`timescale 1ns/1ns

`include "mem_consts.svh"

module initSequencer (
	input logic clk,
	input logic reset,
	input memTypesPkg::bankReq hostReq0,
	input memTypesPkg::bankReq hostReq1,
	output memTypesPkg::bankReq bankReq0,
	output memTypesPkg::bankReq bankReq1,
	output logic ready
);

	import memTypesPkg::*;

	seqState state;
	segNum seg;
	segNum bootField;

	////////////////////////////////////////
	// Load sequencing
	////////////////////////////////////////

	// One segment per clock while loading
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= Idle;
			seg <= segNum'(`BOOT_FIRST);
		end else begin
			case (state)
				Idle: begin
					state <= Load;
					seg <= segNum'(`BOOT_FIRST);
				end
				Load: begin
					if (seg == segNum'(`BOOT_LAST)) begin
						state <= Run;
					end else begin
						seg <= seg + 1'b1;
					end
				end
				default: begin
					state <= Run;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Bank port ownership
	////////////////////////////////////////

	// Upper field of the boot word lags the segment by one
	assign bootField = seg - segNum'(1);

	always_comb begin
		bankReq0 = '0;
		bankReq1 = '0;
		case (state)
			Load: begin
				// Bank 0 at the segment base, bank 1 at the segment top
				bankReq0.en = 1'b1;
				bankReq0.we = 1'b1;
				bankReq0.addr = bankAddr'({seg, {`SEG_BITS{1'b0}}});
				bankReq0.data = bankWord'({bootField, `TAG0});
				bankReq1.en = 1'b1;
				bankReq1.we = 1'b1;
				bankReq1.addr = bankAddr'({seg, {`SEG_BITS{1'b1}}});
				bankReq1.data = bankWord'({bootField, `TAG1});
			end
			Run: begin
				bankReq0 = hostReq0;
				bankReq1 = hostReq1;
			end
			default: begin
			end
		endcase
	end

	assign ready = (state == Run);

endmodule

//--- logic/bankRam.sv
`timescale 1ns/1ns

`include "mem_consts.svh"

module bankRam (
	input logic clk,
	input memTypesPkg::bankReq req,
	output memTypesPkg::bankWord rdata
);

	import memTypesPkg::*;

	localparam int Depth = 1 << `ADDR_BITS;

	bankWord mem [0:Depth-1];

	////////////////////////////////////////
	// Single port, read or write per cycle
	////////////////////////////////////////

	// Read data holds until the next enabled read
	always_ff @(posedge clk) begin
		if (req.en) begin
			if (req.we) begin
				mem[req.addr] <= req.data;
			end else begin
				rdata <= mem[req.addr];
			end
		end
	end

endmodule

//--- logic/axiBankPort.sv
`timescale 1ns/1ns

`include "mem_consts.svh"

module axiBankPort (
	input logic clk,
	input logic reset,
	input logic ready,
	input logic awvalid,
	input axiLitePkg::axiAw aw,
	output logic awready,
	input logic wvalid,
	input axiLitePkg::axiW w,
	output logic wready,
	output logic bvalid,
	output axiLitePkg::axiB b,
	input logic bready,
	input logic arvalid,
	input axiLitePkg::axiAr ar,
	output logic arready,
	output logic rvalid,
	output axiLitePkg::axiR r,
	input logic rready,
	output memTypesPkg::bankReq hostReq0,
	output memTypesPkg::bankReq hostReq1,
	input memTypesPkg::bankWord rdata0,
	input memTypesPkg::bankWord rdata1
);

	import memTypesPkg::*;
	import axiLitePkg::*;

	typedef enum logic [2:0] {
		PortIdle,
		ReadBank,
		ReadMerge,
		ReadResp,
		WriteResp
	} portState;

	portState state;
	logic wrFire;
	logic rdFire;
	segNum seg;
	logic [`AXI_DATA_BITS-1:0] rWord;

	////////////////////////////////////////
	// Handshakes and decode
	////////////////////////////////////////

	// Write wins when both are offered
	assign awready = ready && (state == PortIdle) && awvalid && wvalid;
	assign wready = awready;
	assign arready = ready && (state == PortIdle) && !(awvalid && wvalid);

	assign wrFire = awready;
	assign rdFire = arvalid && arready;

	assign seg = wrFire ? aw.addr[`SEG_COUNT_BITS+1:2] : ar.addr[`SEG_COUNT_BITS+1:2];

	// Each strobe pair covers one bank half
	always_comb begin
		hostReq0.en = wrFire ? (w.strb[1] | w.strb[0]) : rdFire;
		hostReq0.we = wrFire;
		hostReq0.addr = bankAddr'({seg, {`SEG_BITS{1'b0}}});
		hostReq0.data = w.data[15:0];
		hostReq1.en = wrFire ? (w.strb[3] | w.strb[2]) : rdFire;
		hostReq1.we = wrFire;
		hostReq1.addr = bankAddr'({seg, {`SEG_BITS{1'b1}}});
		hostReq1.data = w.data[31:16];
	end

	////////////////////////////////////////
	// Response tracking
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= PortIdle;
		end else begin
			case (state)
				PortIdle: begin
					if (wrFire) begin
						state <= WriteResp;
					end else if (rdFire) begin
						state <= ReadBank;
					end
				end
				ReadBank: state <= ReadMerge;
				ReadMerge: state <= ReadResp;
				ReadResp: begin
					if (rready) begin
						state <= PortIdle;
					end
				end
				WriteResp: begin
					if (bready) begin
						state <= PortIdle;
					end
				end
				default: state <= PortIdle;
			endcase
		end
	end

	// Both bank words are valid one edge after the read was issued
	always_ff @(posedge clk) begin
		if (state == ReadBank) begin
			rWord <= {rdata1, rdata0};
		end
	end

	assign rvalid = (state == ReadResp);
	assign bvalid = (state == WriteResp);
	assign r.data = rWord;
	assign r.resp = respOkay;
	assign b.resp = respOkay;

endmodule

//--- logic/memInitTop.sv
`timescale 1ns/1ns

module memInitTop (
	input logic clk,
	input logic reset,
	input logic awvalid,
	input axiLitePkg::axiAw aw,
	output logic awready,
	input logic wvalid,
	input axiLitePkg::axiW w,
	output logic wready,
	output logic bvalid,
	output axiLitePkg::axiB b,
	input logic bready,
	input logic arvalid,
	input axiLitePkg::axiAr ar,
	output logic arready,
	output logic rvalid,
	output axiLitePkg::axiR r,
	input logic rready
);

	import memTypesPkg::*;

	logic ready;
	bankReq hostReq0;
	bankReq hostReq1;
	bankReq bankReq0;
	bankReq bankReq1;
	bankWord rdata0;
	bankWord rdata1;

	initSequencer initSequencer_i (
		.clk(clk),
		.reset(reset),
		.hostReq0(hostReq0),
		.hostReq1(hostReq1),
		.bankReq0(bankReq0),
		.bankReq1(bankReq1),
		.ready(ready)
	);

	bankRam bank0Ram (
		.clk(clk),
		.req(bankReq0),
		.rdata(rdata0)
	);

	bankRam bank1Ram (
		.clk(clk),
		.req(bankReq1),
		.rdata(rdata1)
	);

	axiBankPort axiBankPort_i (
		.clk(clk),
		.reset(reset),
		.ready(ready),
		.awvalid(awvalid),
		.aw(aw),
		.awready(awready),
		.wvalid(wvalid),
		.w(w),
		.wready(wready),
		.bvalid(bvalid),
		.b(b),
		.bready(bready),
		.arvalid(arvalid),
		.ar(ar),
		.arready(arready),
		.rvalid(rvalid),
		.r(r),
		.rready(rready),
		.hostReq0(hostReq0),
		.hostReq1(hostReq1),
		.rdata0(rdata0),
		.rdata1(rdata1)
	);

endmodule

//--- test/memInitTb.sv
`timescale 1ns/1ns

`include "mem_consts.svh"

module memInitTb;

	import memTypesPkg::*;
	import axiLitePkg::*;

	localparam int Timeout = 64;
	localparam int SegCount = 1 << `SEG_COUNT_BITS;

	typedef struct packed {
		bankWord hi;
		bankWord lo;
		axiResp resp;
	} readResult;

	logic clk;
	logic reset;
	logic awvalid;
	axiAw aw;
	logic awready;
	logic wvalid;
	axiW w;
	logic wready;
	logic bvalid;
	axiB b;
	logic bready;
	logic arvalid;
	axiAr ar;
	logic arready;
	logic rvalid;
	axiR r;
	logic rready;

	integer seed;
	int errors;
	int checks;
	int testNum;
	int testFails;
	int testStartErrors;

	// Expected content of each segment, bank 1 in the upper half
	logic [`AXI_DATA_BITS-1:0] shadow [0:SegCount-1];

	readResult expRd[$];
	readResult gotRd[$];
	axiResp expB[$];
	axiResp gotB[$];

	memInitTop memInitTop_i (
		.clk(clk),
		.reset(reset),
		.awvalid(awvalid),
		.aw(aw),
		.awready(awready),
		.wvalid(wvalid),
		.w(w),
		.wready(wready),
		.bvalid(bvalid),
		.b(b),
		.bready(bready),
		.arvalid(arvalid),
		.ar(ar),
		.arready(arready),
		.rvalid(rvalid),
		.r(r),
		.rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Upper field is the segment minus one, low 5 bits the bank tag
	function automatic bankWord bootWord(input logic bank, input segNum seg);
		bankWord field;
		field = bankWord'(seg - segNum'(1));
		return (field << 5) | bankWord'(bank ? `TAG1 : `TAG0);
	endfunction

	function automatic logic [`AXI_DATA_BITS-1:0] mergeWrite(
		input logic [`AXI_DATA_BITS-1:0] old,
		input logic [`AXI_DATA_BITS-1:0] data,
		input logic [`AXI_STRB_BITS-1:0] strb
	);
		logic [`AXI_DATA_BITS-1:0] merged;
		merged = old;
		// Either strobe of a half writes the whole half
		if (strb[1] || strb[0]) begin
			merged[15:0] = data[15:0];
		end
		if (strb[3] || strb[2]) begin
			merged[31:16] = data[31:16];
		end
		return merged;
	endfunction

	function automatic logic [`AXI_ADDR_BITS-1:0] segAddr(input segNum seg);
		logic [`AXI_ADDR_BITS-1:0] addr;
		// Bits outside the segment field get random junk
		addr = `AXI_ADDR_BITS'($random(seed));
		addr[`SEG_COUNT_BITS+1:2] = seg;
		return addr;
	endfunction

	function automatic segNum randomBootSeg();
		int span;
		span = `BOOT_LAST - `BOOT_FIRST + 1;
		return segNum'(`BOOT_FIRST + $unsigned($random(seed)) % span);
	endfunction

	////////////////////////////////////////
	// Compare and report
	////////////////////////////////////////

	task automatic checkWord(input string what, input bankWord got, input bankWord exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkResp(input string what, input axiResp got, input axiResp exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s was %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic flagError(input string what);
		errors++;
		$display("Error at %0t ns: %s", $time, what);
	endtask

	task automatic abortRun(input string what);
		$display("Timed out at %0t ns while waiting for %s", $time, what);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	// Results are queued at falling edges and checked here
	always @(posedge clk) begin : compare
		readResult expR;
		readResult gotR;
		while (gotRd.size() > 0 && expRd.size() > 0) begin
			expR = expRd.pop_front();
			gotR = gotRd.pop_front();
			checkWord("bank 0 half", gotR.lo, expR.lo);
			checkWord("bank 1 half", gotR.hi, expR.hi);
			checkResp("read response", gotR.resp, expR.resp);
		end
		while (gotB.size() > 0 && expB.size() > 0) begin
			checkResp("write response", gotB.pop_front(), expB.pop_front());
		end
	end

	////////////////////////////////////////
	// AXI driver tasks
	////////////////////////////////////////

	// Called and left just after a falling edge
	task automatic axiRead(input segNum seg, input int hold, output axiR got, output int waited);
		bit done;
		int n;
		int i;
		ar.addr = segAddr(seg);
		ar.prot = 3'b000;
		arvalid = 1'b1;
		waited = 0;
		done = 1'b0;
		while (!done) begin
			@(posedge clk);
			if (arready) begin
				done = 1'b1;
			end else begin
				waited++;
				if (waited >= Timeout) begin
					abortRun("arready");
				end
			end
		end
		@(negedge clk);
		arvalid = 1'b0;
		n = 0;
		while (!rvalid) begin
			@(negedge clk);
			n++;
			if (n >= Timeout) begin
				abortRun("rvalid");
			end
		end
		if (n != 2) begin
			flagError("rvalid did not rise two edges after the address was taken");
		end
		got = r;
		// Competing write offered while the response is held
		if (hold > 0) begin
			aw.addr = segAddr(seg);
			w.data = `AXI_DATA_BITS'($random(seed));
			w.strb = '1;
			awvalid = 1'b1;
			wvalid = 1'b1;
		end
		for (i = 0; i < hold; i++) begin
			@(posedge clk);
			if (awready || wready || arready) begin
				flagError("transaction accepted while a read response was pending");
			end
			@(negedge clk);
			if (!rvalid || r !== got) begin
				flagError("read response dropped or changed before rready");
			end
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		rready = 1'b1;
		@(posedge clk);
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic axiWrite(
		input segNum seg,
		input logic [`AXI_DATA_BITS-1:0] data,
		input logic [`AXI_STRB_BITS-1:0] strb,
		input int hold,
		output axiResp resp
	);
		bit done;
		int n;
		int i;
		axiB held;
		aw.addr = segAddr(seg);
		aw.prot = 3'b000;
		w.data = data;
		w.strb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		n = 0;
		done = 1'b0;
		while (!done) begin
			@(posedge clk);
			if (awready != wready) begin
				flagError("awready and wready differ");
			end
			if (awready && wready) begin
				done = 1'b1;
			end else begin
				n++;
				if (n >= Timeout) begin
					abortRun("awready and wready");
				end
			end
		end
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		n = 0;
		while (!bvalid) begin
			@(negedge clk);
			n++;
			if (n >= Timeout) begin
				abortRun("bvalid");
			end
		end
		if (n != 0) begin
			flagError("bvalid did not rise on the edge after the write was taken");
		end
		held = b;
		if (hold > 0) begin
			ar.addr = segAddr(seg);
			arvalid = 1'b1;
		end
		for (i = 0; i < hold; i++) begin
			@(posedge clk);
			if (awready || wready || arready) begin
				flagError("transaction accepted while a write response was pending");
			end
			@(negedge clk);
			if (!bvalid || b !== held) begin
				flagError("write response dropped or changed before bready");
			end
		end
		arvalid = 1'b0;
		bready = 1'b1;
		@(posedge clk);
		@(negedge clk);
		bready = 1'b0;
		resp = held.resp;
	endtask

	task automatic readCompare(input segNum seg, input int hold, output int waited);
		axiR got;
		readResult e;
		readResult g;
		axiRead(seg, hold, got, waited);
		e.hi = shadow[seg][31:16];
		e.lo = shadow[seg][15:0];
		e.resp = respOkay;
		g.hi = got.data[31:16];
		g.lo = got.data[15:0];
		g.resp = got.resp;
		expRd.push_back(e);
		gotRd.push_back(g);
	endtask

	task automatic writeTrack(
		input segNum seg,
		input logic [`AXI_DATA_BITS-1:0] data,
		input logic [`AXI_STRB_BITS-1:0] strb,
		input int hold
	);
		axiResp resp;
		axiWrite(seg, data, strb, hold, resp);
		shadow[seg] = mergeWrite(shadow[seg], data, strb);
		expB.push_back(respOkay);
		gotB.push_back(resp);
	endtask

	task automatic startTest();
		testNum++;
		testStartErrors = errors;
	endtask

	task automatic endTest(input string name);
		int n;
		n = 0;
		while (gotRd.size() > 0 || gotB.size() > 0) begin
			@(posedge clk);
			n++;
			if (n >= Timeout) begin
				abortRun("the checker to drain");
			end
		end
		@(negedge clk);
		if (errors == testStartErrors) begin
			$display("Test %0d %s: ok", testNum, name);
		end else begin
			testFails++;
			$display("Test %0d %s: failed with %0d errors", testNum, name,
				errors - testStartErrors);
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin : stimulus
		int i;
		int k;
		int waited;
		int hold;
		segNum seg;
		logic [`AXI_DATA_BITS-1:0] data;
		logic [`AXI_STRB_BITS-1:0] strb;
		seed = 32'h61b6_8689;
		errors = 0;
		checks = 0;
		testNum = 0;
		testFails = 0;
		reset = 1'b1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		arvalid = 1'b0;
		rready = 1'b0;
		aw = '0;
		w = '0;
		ar = '0;
		for (k = 0; k < SegCount; k++) begin
			shadow[k] = 'x;
		end
		for (k = `BOOT_FIRST; k <= `BOOT_LAST; k++) begin
			shadow[k] = {bootWord(1'b1, segNum'(k)), bootWord(1'b0, segNum'(k))};
		end
		for (i = 0; i < 5; i++) begin
			@(posedge clk);
		end
		@(negedge clk);
		reset = 1'b0;

		// Address offered right away, taken only after the boot load
		startTest();
		readCompare(segNum'(`BOOT_FIRST), 0, waited);
		// One Idle cycle, then one Load cycle per boot segment
		if (waited != `BOOT_LAST - `BOOT_FIRST + 2) begin
			flagError("arready did not rise right after the boot load finished");
		end
		endTest("read held off until boot load");

		startTest();
		for (k = `BOOT_FIRST; k <= `BOOT_LAST; k++) begin
			readCompare(segNum'(k), 0, waited);
		end
		endTest("boot words of all segments");

		startTest();
		for (i = 0; i < 8; i++) begin
			seg = randomBootSeg();
			data = `AXI_DATA_BITS'($random(seed));
			writeTrack(seg, data, 4'b1111, 0);
			readCompare(seg, 0, waited);
		end
		endTest("full strobe write and read back");

		startTest();
		for (i = 0; i < 8; i++) begin
			case (i % 4)
				0: strb = 4'b0001;
				1: strb = 4'b0011;
				2: strb = 4'b0100;
				default: strb = 4'b1100;
			endcase
			seg = randomBootSeg();
			data = `AXI_DATA_BITS'($random(seed));
			writeTrack(seg, data, strb, 0);
			readCompare(seg, 0, waited);
		end
		endTest("half strobe writes");

		startTest();
		for (i = 0; i < 4; i++) begin
			seg = randomBootSeg();
			data = `AXI_DATA_BITS'($random(seed));
			hold = 1 + $unsigned($random(seed)) % 6;
			writeTrack(seg, data, 4'b1111, hold);
			hold = 1 + $unsigned($random(seed)) % 6;
			readCompare(seg, hold, waited);
		end
		endTest("responses held by back-pressure");

		startTest();
		writeTrack(segNum'(0), `AXI_DATA_BITS'($random(seed)), 4'b1111, 0);
		writeTrack(segNum'(SegCount - 1), `AXI_DATA_BITS'($random(seed)), 4'b1111, 0);
		readCompare(segNum'(0), 0, waited);
		readCompare(segNum'(SegCount - 1), 0, waited);
		endTest("segments outside the boot range");

		$display("%0d tests, %0d failed, %0d checks, %0d errors", testNum, testFails,
			checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+logic
logic/memTypesPkg.sv
logic/axiLitePkg.sv
logic/initSequencer.sv
logic/bankRam.sv
logic/axiBankPort.sv
logic/memInitTop.sv
test/memInitTb.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing -Wno-fatal -f files.f --top-module memInitTb \
	-Mdir "$buildDir" -o memInitSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/memInitSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$logFile"; then
	exit 1
fi

if ! grep -q "TESTBENCH PASSED" "$logFile"; then
	echo "Simulation ended without a result"
	exit 1
fi

exit 0
